// ==== dual_issue.f ====
+incdir+design
design/issue_pkg.sv
design/head_if.sv
design/issue_queue.sv
design/pair_check.sv
design/exec_latch.sv
design/issue_counters.sv
design/issue_stage.sv
sim/tb_issue_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_issue_stage -f dual_issue.f
output=$(./obj_dir/Vtb_issue_stage)
echo "$output"
if echo "$output" | grep -q '^>>> PASS$'
then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

// ==== sim/tb_issue_stage.sv ====
`include "issue_cfg.svh"

module tb_issue_stage;

    localparam int NUM_TESTS = 7;
    localparam int CYCLES_PER_TEST = 200;
    localparam logic [31:0] SEED = 32'h104b4146;

    logic clk;
    logic reset;
    logic stall;
    logic flush;
    issue_pkg::decode_data_t [1:0] in_data;
    logic [1:0] hit;
    logic full;
    logic [3:0][4:0] reg_addr;
    logic [3:0][31:0] reg_data;
    logic [3:0] reg_ready;
    issue_pkg::issue_data_t [1:0] issue_out;
    logic [`ISSUE_COUNT_WIDTH-1:0] single_count;
    logic [`ISSUE_COUNT_WIDTH-1:0] dual_count;

    // one ready bit per architectural register
    logic [31:0] ready_map;
    logic [`ISSUE_COUNT_WIDTH-1:0] exp_single;
    logic [`ISSUE_COUNT_WIDTH-1:0] exp_dual;
    int slot_errors;
    int count_errors;
    int bit_errors;

    issue_stage issue_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .in_data      (in_data),
        .hit          (hit),
        .full         (full),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .reg_ready    (reg_ready),
        .issue_out    (issue_out),
        .single_count (single_count),
        .dual_count   (dual_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] r);
        return xorshift(SEED ^ {27'd0, r});
    endfunction

    // register file model, answers in the same cycle
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            reg_data[i]  = reg_value(reg_addr[i]);
            reg_ready[i] = ready_map[reg_addr[i]];
        end
    end

    function automatic issue_pkg::decode_data_t make_entry(input issue_pkg::op_t op,
        input logic [4:0] dest, input logic [4:0] rs, input logic [4:0] rt,
        input logic [31:0] pc);
        issue_pkg::decode_data_t d;
        d.op          = op;
        d.destreg     = dest;
        d.srcrega     = rs;
        d.srcregb     = rt;
        d.writes_dest = dest != 5'd0;
        d.pc          = pc;
        d.imm         = pc[17:2];
        return d;
    endfunction

    function automatic issue_pkg::issue_data_t expected_slot(input issue_pkg::decode_data_t d);
        issue_pkg::issue_data_t s;
        s.op          = d.op;
        s.destreg     = d.destreg;
        s.writes_dest = d.writes_dest;
        s.pc          = d.pc;
        s.imm         = d.imm;
        s.rs_val      = reg_value(d.srcrega);
        s.rt_val      = reg_value(d.srcregb);
        s.rs_ready    = ready_map[d.srcrega];
        s.rt_ready    = ready_map[d.srcregb];
        // jal links to the instruction after its delay slot
        if (d.op == issue_pkg::OP_JAL)
        begin
            s.rt_val   = d.pc + 32'd8;
            s.rt_ready = 1'b1;
        end
        return s;
    endfunction

    task automatic compare_slot(input issue_pkg::issue_data_t got,
        input issue_pkg::issue_data_t exp, input string name);
        if (got !== exp)
        begin
            slot_errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input logic [`ISSUE_COUNT_WIDTH-1:0] got,
        input logic [`ISSUE_COUNT_WIDTH-1:0] exp, input string name);
        if (got !== exp)
        begin
            count_errors++;
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            bit_errors++;
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic write_entries(input issue_pkg::decode_data_t older,
        input issue_pkg::decode_data_t younger, input logic [1:0] strobes);
        @(posedge clk);
        in_data[1] <= older;
        in_data[0] <= younger;
        hit        <= strobes;
        @(posedge clk);
        hit <= 2'b00;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic expect_dual(input issue_pkg::decode_data_t a, input issue_pkg::decode_data_t b);
        compare_slot(issue_out[1], expected_slot(a), "issue_out[1]");
        compare_slot(issue_out[0], expected_slot(b), "issue_out[0]");
        exp_dual = exp_dual + `ISSUE_COUNT_WIDTH'd1;
    endtask

    task automatic expect_single(input issue_pkg::decode_data_t a);
        compare_slot(issue_out[1], expected_slot(a), "issue_out[1]");
        compare_slot(issue_out[0], '0, "issue_out[0]");
        exp_single = exp_single + `ISSUE_COUNT_WIDTH'd1;
    endtask

    task automatic expect_bubble();
        compare_slot(issue_out[1], '0, "issue_out[1]");
        compare_slot(issue_out[0], '0, "issue_out[0]");
    endtask

    task automatic expect_counts();
        compare_count(single_count, exp_single, "single_count");
        compare_count(dual_count, exp_dual, "dual_count");
    endtask

    task automatic after_reset();
        expect_bubble();
        expect_counts();
        compare_bit(full, 1'b0, "full");
    endtask

    task automatic dual_alu_pairs();
        issue_pkg::decode_data_t a;
        issue_pkg::decode_data_t b;
        a = make_entry(issue_pkg::OP_ALU, 5'd3, 5'd1, 5'd2, 32'h1000);
        b = make_entry(issue_pkg::OP_ALU, 5'd4, 5'd5, 5'd6, 32'h1004);
        write_entries(a, b, 2'b11);
        next_cycle();
        expect_dual(a, b);
        // r13 still waiting on writeback
        ready_map[13] = 1'b0;
        a = make_entry(issue_pkg::OP_ALU, 5'd12, 5'd13, 5'd14, 32'h1008);
        b = make_entry(issue_pkg::OP_ALU, 5'd15, 5'd16, 5'd13, 32'h100c);
        write_entries(a, b, 2'b11);
        next_cycle();
        expect_dual(a, b);
        ready_map = '1;
        next_cycle();
        expect_bubble();
    endtask

    task automatic split_pair(input issue_pkg::decode_data_t a, input issue_pkg::decode_data_t b);
        write_entries(a, b, 2'b11);
        next_cycle();
        expect_single(a);
        next_cycle();
        expect_single(b);
    endtask

    task automatic pairing_rules();
        issue_pkg::decode_data_t a;
        issue_pkg::decode_data_t br;
        issue_pkg::decode_data_t d;
        split_pair(make_entry(issue_pkg::OP_ALU, 5'd7, 5'd1, 5'd2, 32'h2000),
                   make_entry(issue_pkg::OP_ALU, 5'd8, 5'd3, 5'd7, 32'h2004));
        split_pair(make_entry(issue_pkg::OP_LOAD, 5'd9, 5'd10, 5'd0, 32'h2008),
                   make_entry(issue_pkg::OP_STORE, 5'd0, 5'd11, 5'd12, 32'h200c));
        split_pair(make_entry(issue_pkg::OP_MULDIV, 5'd0, 5'd1, 5'd2, 32'h2010),
                   make_entry(issue_pkg::OP_MULDIV, 5'd0, 5'd3, 5'd4, 32'h2014));
        split_pair(make_entry(issue_pkg::OP_PRIV, 5'd0, 5'd1, 5'd2, 32'h2018),
                   make_entry(issue_pkg::OP_ALU, 5'd5, 5'd1, 5'd2, 32'h201c));
        split_pair(make_entry(issue_pkg::OP_ALU, 5'd6, 5'd1, 5'd2, 32'h2020),
                   make_entry(issue_pkg::OP_PRIV, 5'd0, 5'd3, 5'd4, 32'h2024));
        // branch in b goes on to wait for its own delay slot
        a  = make_entry(issue_pkg::OP_ALU, 5'd10, 5'd1, 5'd2, 32'h2028);
        br = make_entry(issue_pkg::OP_BRANCH, 5'd0, 5'd3, 5'd4, 32'h202c);
        d  = make_entry(issue_pkg::OP_ALU, 5'd11, 5'd5, 5'd6, 32'h2030);
        write_entries(a, br, 2'b11);
        next_cycle();
        expect_single(a);
        next_cycle();
        expect_bubble();
        write_entries(d, d, 2'b10);
        next_cycle();
        expect_dual(br, d);
    endtask

    task automatic delay_slot_wait(input issue_pkg::decode_data_t ctrl,
        input issue_pkg::decode_data_t slot);
        write_entries(ctrl, ctrl, 2'b10);
        repeat (3)
        begin
            next_cycle();
            expect_bubble();
        end
        write_entries(slot, slot, 2'b10);
        next_cycle();
        expect_dual(ctrl, slot);
    endtask

    task automatic jal_link();
        // link value is ready even while r7 is still pending
        ready_map[7] = 1'b0;
        delay_slot_wait(make_entry(issue_pkg::OP_JAL, 5'd31, 5'd0, 5'd7, 32'h6000),
                        make_entry(issue_pkg::OP_ALU, 5'd2, 5'd5, 5'd6, 32'h6004));
        ready_map = '1;
    endtask

    task automatic full_under_stall();
        issue_pkg::decode_data_t fa [5];
        issue_pkg::decode_data_t fb [5];
        for (int i = 0; i < 5; i++)
        begin
            fa[i] = make_entry(issue_pkg::OP_ALU, 5'(16 + i), 5'(i + 1), 5'd0,
                               32'h3000 + 32'(8 * i));
            fb[i] = make_entry(issue_pkg::OP_ALU, 5'(24 + i), 5'(i + 2), 5'd30,
                               32'h3004 + 32'(8 * i));
        end
        @(posedge clk);
        stall <= 1'b1;
        for (int i = 0; i < 4; i++)
            write_entries(fa[i], fb[i], 2'b11);
        // ninth and tenth entry have no room and are dropped
        @(posedge clk);
        in_data[1] <= make_entry(issue_pkg::OP_ALU, 5'd1, 5'd2, 5'd3, 32'hdead0000);
        in_data[0] <= make_entry(issue_pkg::OP_ALU, 5'd4, 5'd5, 5'd6, 32'hdead0004);
        hit        <= 2'b11;
        @(negedge clk);
        compare_bit(full, 1'b1, "full");
        @(posedge clk);
        hit   <= 2'b00;
        stall <= 1'b0;
        next_cycle();
        expect_dual(fa[0], fb[0]);
        @(posedge clk);
        in_data[1] <= fa[4];
        in_data[0] <= fb[4];
        hit        <= 2'b11;
        @(negedge clk);
        compare_bit(full, 1'b0, "full");
        expect_dual(fa[1], fb[1]);
        @(posedge clk);
        hit <= 2'b00;
        @(negedge clk);
        expect_dual(fa[2], fb[2]);
        for (int i = 3; i < 5; i++)
        begin
            next_cycle();
            expect_dual(fa[i], fb[i]);
        end
        next_cycle();
        expect_bubble();
    endtask

    task automatic stall_and_flush();
        issue_pkg::decode_data_t p;
        issue_pkg::decode_data_t q;
        p = make_entry(issue_pkg::OP_ALU, 5'd3, 5'd4, 5'd5, 32'h4000);
        q = make_entry(issue_pkg::OP_ALU, 5'd6, 5'd7, 5'd8, 32'h4004);
        write_entries(p, q, 2'b11);
        // p and q issue at this edge, r and s get stuck behind the stall
        @(posedge clk);
        stall      <= 1'b1;
        in_data[1] <= make_entry(issue_pkg::OP_ALU, 5'd9, 5'd10, 5'd11, 32'h4008);
        in_data[0] <= make_entry(issue_pkg::OP_ALU, 5'd12, 5'd13, 5'd14, 32'h400c);
        hit        <= 2'b11;
        @(posedge clk);
        hit <= 2'b00;
        @(negedge clk);
        expect_dual(p, q);
        expect_counts();
        repeat (2)
        begin
            next_cycle();
            compare_slot(issue_out[1], expected_slot(p), "issue_out[1]");
            compare_slot(issue_out[0], expected_slot(q), "issue_out[0]");
            expect_counts();
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        @(negedge clk);
        expect_bubble();
        repeat (4)
        begin
            next_cycle();
            expect_bubble();
        end
        expect_counts();
    endtask

    initial
    begin
        reset     <= 1'b0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        hit       <= 2'b00;
        in_data   <= '0;
        ready_map = '1;
        exp_single = '0;
        exp_dual   = '0;
        slot_errors  = 0;
        count_errors = 0;
        bit_errors   = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        after_reset();
        dual_alu_pairs();
        pairing_rules();
        delay_slot_wait(make_entry(issue_pkg::OP_BRANCH, 5'd0, 5'd3, 5'd4, 32'h5000),
                        make_entry(issue_pkg::OP_ALU, 5'd9, 5'd3, 5'd5, 32'h5004));
        jal_link();
        full_under_stall();
        stall_and_flush();
        expect_counts();
        $display("errors: slot %0d, count %0d, bit %0d", slot_errors, count_errors,
                 bit_errors);
        if (slot_errors + count_errors + bit_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: tests still running after %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== design/issue_stage.sv ====
`include "issue_cfg.svh"

module issue_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  issue_pkg::decode_data_t [1:0] in_data,
    input  logic [1:0]                    hit,
    output logic                          full,
    output logic [3:0][4:0]               reg_addr,
    input  logic [3:0][31:0]              reg_data,
    input  logic [3:0]                    reg_ready,
    output issue_pkg::issue_data_t [1:0]  issue_out,
    output logic [`ISSUE_COUNT_WIDTH-1:0] single_count,
    output logic [`ISSUE_COUNT_WIDTH-1:0] dual_count
);

    head_if head_bus ();

    issue_queue issue_queue_inst (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .flush   (flush),
        .in_data (in_data),
        .hit     (hit),
        .full    (full),
        .head    (head_bus.queue)
    );

    pair_check pair_check_inst (
        .head (head_bus.pairing)
    );

    exec_latch exec_latch_inst (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .head      (head_bus.latch),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data),
        .reg_ready (reg_ready),
        .issue_out (issue_out)
    );

    issue_counters issue_counters_inst (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .issue_en     (head_bus.issue_en),
        .single_count (single_count),
        .dual_count   (dual_count)
    );

endmodule

// ==== design/issue_counters.sv ====
`include "issue_cfg.svh"

module issue_counters (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [1:0]                    issue_en,
    output logic [`ISSUE_COUNT_WIDTH-1:0] single_count,
    output logic [`ISSUE_COUNT_WIDTH-1:0] dual_count
);

    logic count_en;

    // an issue only counts when execute actually takes it
    assign count_en = !stall && !flush;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            single_count <= '0;
            dual_count   <= '0;
        end
        else if (count_en)
        begin
            if (issue_en == 2'b11)
                dual_count <= dual_count + `ISSUE_COUNT_WIDTH'd1;
            if (issue_en == 2'b10)
                single_count <= single_count + `ISSUE_COUNT_WIDTH'd1;
        end
    end

endmodule

// ==== design/exec_latch.sv ====
module exec_latch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         flush,
    head_if.latch                        head,
    output logic [3:0][4:0]              reg_addr,
    input  logic [3:0][31:0]             reg_data,
    input  logic [3:0]                   reg_ready,
    output issue_pkg::issue_data_t [1:0] issue_out
);

    issue_pkg::issue_data_t slot_a;
    issue_pkg::issue_data_t slot_b;
    issue_pkg::issue_data_t [1:0] slot_next;

    function automatic issue_pkg::issue_data_t build_slot(
        input issue_pkg::decode_data_t entry,
        input logic [31:0]             rs_val,
        input logic [31:0]             rt_val,
        input logic                    rs_ready,
        input logic                    rt_ready
    );
        issue_pkg::issue_data_t slot;
        slot.op          = entry.op;
        slot.destreg     = entry.destreg;
        slot.writes_dest = entry.writes_dest;
        slot.pc          = entry.pc;
        slot.imm         = entry.imm;
        slot.rs_val      = rs_val;
        slot.rt_val      = rt_val;
        slot.rs_ready    = rs_ready;
        slot.rt_ready    = rt_ready;
        // link address skips the delay slot
        if (entry.op == issue_pkg::OP_JAL)
        begin
            slot.rt_val   = entry.pc + 32'd8;
            slot.rt_ready = 1'b1;
        end
        return slot;
    endfunction

    // rs a, rt a, rs b, rt b from high index down
    assign reg_addr[3] = head.entry_a.srcrega;
    assign reg_addr[2] = head.entry_a.srcregb;
    assign reg_addr[1] = head.entry_b.srcrega;
    assign reg_addr[0] = head.entry_b.srcregb;

    assign slot_a = build_slot(head.entry_a, reg_data[3], reg_data[2],
                               reg_ready[3], reg_ready[2]);
    assign slot_b = build_slot(head.entry_b, reg_data[1], reg_data[0],
                               reg_ready[1], reg_ready[0]);

    // slots not issued go out as bubbles
    assign slot_next[1] = head.issue_en[1] ? slot_a : '0;
    assign slot_next[0] = head.issue_en[0] ? slot_b : '0;

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
        begin
            issue_out <= '0;
        end
        else if (!stall)
        begin
            issue_out <= slot_next;
        end
    end

endmodule

// ==== design/pair_check.sv ====
module pair_check (
    head_if.pairing head
);

    logic ctrl_a;
    logic ctrl_b;
    logic mem_a;
    logic mem_b;
    logic raw_hazard;
    logic mem_pair;
    logic priv_any;
    logic muldiv_pair;
    logic en_a;
    logic en_b;

    // branches and jumps carry a delay slot
    assign ctrl_a = head.entry_a.op == issue_pkg::OP_BRANCH ||
                    head.entry_a.op == issue_pkg::OP_JUMP ||
                    head.entry_a.op == issue_pkg::OP_JAL;
    assign ctrl_b = head.entry_b.op == issue_pkg::OP_BRANCH ||
                    head.entry_b.op == issue_pkg::OP_JUMP ||
                    head.entry_b.op == issue_pkg::OP_JAL;

    assign mem_a = head.entry_a.op == issue_pkg::OP_LOAD ||
                   head.entry_a.op == issue_pkg::OP_STORE;
    assign mem_b = head.entry_b.op == issue_pkg::OP_LOAD ||
                   head.entry_b.op == issue_pkg::OP_STORE;

    // only one memory port in execute
    assign mem_pair = mem_a && mem_b;

    // no forwarding between the two slots
    assign raw_hazard = head.entry_a.writes_dest &&
                        (head.entry_a.destreg == head.entry_b.srcrega ||
                         head.entry_a.destreg == head.entry_b.srcregb);

    assign priv_any = head.entry_a.op == issue_pkg::OP_PRIV ||
                      head.entry_b.op == issue_pkg::OP_PRIV;

    assign muldiv_pair = head.entry_a.op == issue_pkg::OP_MULDIV &&
                         head.entry_b.op == issue_pkg::OP_MULDIV;

    // a branch waits until its delay slot is at the head too
    assign en_a = head.valid_a && !(ctrl_a && !head.valid_b);

    assign en_b = en_a && head.valid_b &&
                  !(ctrl_b || mem_pair || raw_hazard || priv_any || muldiv_pair);

    assign head.issue_en = {en_a, en_b};

endmodule

// ==== design/issue_queue.sv ====
`include "issue_cfg.svh"

module issue_queue (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  issue_pkg::decode_data_t [1:0] in_data,
    input  logic [1:0]                    hit,
    output logic                          full,
    head_if.queue                         head
);

    issue_pkg::decode_data_t entries [`ISSUE_QUEUE_SIZE];
    logic [`ISSUE_QUEUE_SIZE-1:0] valid;
    logic [`ISSUE_QUEUE_SIZE-1:0] valid_next;

    logic [`ISSUE_QUEUE_WIDTH-1:0] head_ptr;
    logic [`ISSUE_QUEUE_WIDTH-1:0] tail_ptr;
    logic [`ISSUE_QUEUE_WIDTH-1:0] head_plus1;
    logic [`ISSUE_QUEUE_WIDTH-1:0] head_plus2;
    logic [`ISSUE_QUEUE_WIDTH-1:0] tail_plus1;
    logic [`ISSUE_QUEUE_WIDTH-1:0] tail_plus2;
    logic [`ISSUE_QUEUE_WIDTH-1:0] head_next;
    logic [`ISSUE_QUEUE_WIDTH-1:0] tail_next;
    logic [`ISSUE_QUEUE_WIDTH-1:0] wr_slot_b;

    logic accept;

    // pointers wrap naturally at the queue size
    assign head_plus1 = head_ptr + `ISSUE_QUEUE_WIDTH'd1;
    assign head_plus2 = head_ptr + `ISSUE_QUEUE_WIDTH'd2;
    assign tail_plus1 = tail_ptr + `ISSUE_QUEUE_WIDTH'd1;
    assign tail_plus2 = tail_ptr + `ISSUE_QUEUE_WIDTH'd2;

    // the younger entry goes behind the older one, or to tail if alone
    assign wr_slot_b = hit[1] ? tail_plus1 : tail_ptr;

    always_comb
    begin
        case (hit)
            2'b11:   full = valid[tail_ptr] || valid[tail_plus1];
            2'b10:   full = valid[tail_ptr];
            2'b01:   full = valid[tail_ptr];
            default: full = 1'b0;
        endcase
    end

    assign accept = !full && !flush;

    assign head.valid_a = valid[head_ptr];
    assign head.valid_b = valid[head_plus1];
    assign head.entry_a = valid[head_ptr] ? entries[head_ptr] : '0;
    assign head.entry_b = valid[head_plus1] ? entries[head_plus1] : '0;

    always_comb
    begin
        valid_next = valid;
        head_next  = head_ptr;
        tail_next  = tail_ptr;
        // retire what execute takes this edge
        if (!stall)
        begin
            case (head.issue_en)
                2'b11:
                begin
                    valid_next[head_ptr]   = 1'b0;
                    valid_next[head_plus1] = 1'b0;
                    head_next              = head_plus2;
                end
                2'b10:
                begin
                    valid_next[head_ptr] = 1'b0;
                    head_next            = head_plus1;
                end
                default:
                begin
                    head_next = head_ptr;
                end
            endcase
        end
        // full guarantees these slots are free
        if (accept)
        begin
            if (hit[1])
                valid_next[tail_ptr] = 1'b1;
            if (hit[0])
                valid_next[wr_slot_b] = 1'b1;
            case (hit)
                2'b11:   tail_next = tail_plus2;
                2'b10:   tail_next = tail_plus1;
                2'b01:   tail_next = tail_plus1;
                default: tail_next = tail_ptr;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && hit[1])
            entries[tail_ptr] <= in_data[1];
        if (accept && hit[0])
            entries[wr_slot_b] <= in_data[0];
    end

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
        begin
            valid    <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end
        else
        begin
            valid    <= valid_next;
            head_ptr <= head_next;
            tail_ptr <= tail_next;
        end
    end

endmodule

// ==== design/head_if.sv ====
interface head_if;

    // two oldest queue entries, zero when not valid
    issue_pkg::decode_data_t entry_a;
    issue_pkg::decode_data_t entry_b;
    logic valid_a;
    logic valid_b;

    // bit 1 issues slot a, bit 0 issues slot b
    logic [1:0] issue_en;

    modport queue (output entry_a, entry_b, valid_a, valid_b, input issue_en);

    modport pairing (input entry_a, entry_b, valid_a, valid_b, output issue_en);

    modport latch (input entry_a, entry_b, issue_en);

endinterface

// ==== design/issue_pkg.sv ====
package issue_pkg;

    // instruction classes as seen by the issue stage
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ALU    = 4'd1,
        OP_LOAD   = 4'd2,
        OP_STORE  = 4'd3,
        OP_BRANCH = 4'd4,
        OP_JUMP   = 4'd5,
        OP_JAL    = 4'd6,
        OP_MULDIV = 4'd7,
        OP_PRIV   = 4'd8
    } op_t;

    // one decoded instruction as delivered by decode
    typedef struct packed {
        op_t         op;
        logic [4:0]  destreg;
        logic [4:0]  srcrega;
        logic [4:0]  srcregb;
        logic        writes_dest;
        logic [31:0] pc;
        logic [15:0] imm;
    } decode_data_t;

    // one slot toward execute
    // all zero is a bubble with op OP_NOP
    typedef struct packed {
        op_t         op;
        logic [4:0]  destreg;
        logic        writes_dest;
        logic [31:0] pc;
        logic [15:0] imm;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic        rs_ready;
        logic        rt_ready;
    } issue_data_t;

endpackage

// ==== design/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// issue queue entries, must be a power of two
`define ISSUE_QUEUE_SIZE 8

// head and tail pointer width, log2 of the queue size
`define ISSUE_QUEUE_WIDTH 3

`define ISSUE_COUNT_WIDTH 32

`endif
